// File: source/lpif_link_cfg.svh
`ifndef LPIF_LINK_CFG_SVH
`define LPIF_LINK_CFG_SVH

////////////////////////////////////////
// LPIF field widths
////////////////////////////////////////

`define LPIF_STATE_W    8
`define LPIF_PROTID_W   4
`define LPIF_DATA_W     128
`define LPIF_DVALID_W   2
`define LPIF_CRC_W      16
`define LPIF_CRCV_W     2
`define LPIF_VALID_W    2

// Field sum is 162, top 2 bits are zero pad
`define LPIF_WORD_W     164

////////////////////////////////////////
// PHY lane layout
////////////////////////////////////////

`define LPIF_LANES      4
`define LPIF_LANE_PAY_W 41
`define LPIF_MRK_W      2
// Payload in [40:0], strobe at 41, marker in [43:42]
`define LPIF_LANE_W     44
`define LPIF_DELAY_W    16

`endif

// File: source/lpif_link_pkg.sv
`include "lpif_link_cfg.svh"

`default_nettype none

package lpif_link_pkg;

  ////////////////////////////////////////
  // LPIF transfer fields
  ////////////////////////////////////////

  typedef logic [`LPIF_STATE_W-1:0]  state_t;
  typedef logic [`LPIF_PROTID_W-1:0] protid_t;
  typedef logic [`LPIF_DATA_W-1:0]   data_t;
  typedef logic [`LPIF_DVALID_W-1:0] dvalid_t;
  typedef logic [`LPIF_CRC_W-1:0]    crc_t;
  typedef logic [`LPIF_CRCV_W-1:0]   crcv_t;
  typedef logic [`LPIF_VALID_W-1:0]  valid_t;

  // Flat transfer word
  // From LSB data, crc, crc_valid, dvalid, valid, protid, state, pad
  typedef logic [`LPIF_WORD_W-1:0]   word_t;

  ////////////////////////////////////////
  // PHY side and control
  ////////////////////////////////////////

  // One lane word with strobe and marker on top
  typedef logic [`LPIF_LANE_W-1:0]   lane_t;
  typedef logic [`LPIF_MRK_W-1:0]    mrk_t;

  // Cycle count for online delays and strobe period
  typedef logic [`LPIF_DELAY_W-1:0]  delay_t;
  typedef logic [31:0]               dbg_t;

endpackage

`default_nettype wire

// File: source/lpif_auto_sync.sv
`default_nettype none

module lpif_auto_sync (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  // Raw online levels
  input  logic                  tx_online,
  input  logic                  rx_online,
  // Rx delay, tx delay, strobe period
  input  lpif_link_pkg::delay_t delay_x_value,
  input  lpif_link_pkg::delay_t delay_y_value,
  input  lpif_link_pkg::delay_t delay_z_value,
  input  lpif_link_pkg::mrk_t   tx_mrk_userbit,
  input  logic                  tx_stb_userbit,
  output logic                  tx_online_delay,
  output logic                  rx_online_delay,
  output logic                  tx_auto_stb_userbit,
  output lpif_link_pkg::mrk_t   tx_auto_mrk_userbit,
  output lpif_link_pkg::dbg_t   tx_downstream_debug_status,
  output lpif_link_pkg::dbg_t   rx_upstream_debug_status
);

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_COUNTING,
    SYNC_ONLINE
  } sync_state_e;

  // Index 0 is tx, index 1 is rx
  logic [1:0]            dir_online;
  lpif_link_pkg::delay_t dir_delay [2];
  logic [1:0]            dir_level;

  lpif_link_pkg::delay_t stb_phase;
  lpif_link_pkg::delay_t stb_period;
  lpif_link_pkg::dbg_t   link_status;

  assign dir_online   = {rx_online, tx_online};
  assign dir_delay[0] = delay_y_value;
  assign dir_delay[1] = delay_x_value;

  ////////////////////////////////////////
  // Online delay per direction
  ////////////////////////////////////////

  for (genvar d = 0; d < 2; d++) begin : g_dir
    sync_state_e           state_q;
    lpif_link_pkg::delay_t cnt_q;

    // Delays of 0 and 1 both go online on the next edge
    always_ff @(posedge clk_wr) begin
      if (!rst_n || !dir_online[d]) begin
        state_q <= SYNC_OFFLINE;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          SYNC_OFFLINE: begin
            if (dir_delay[d] < lpif_link_pkg::delay_t'(2)) begin
              state_q <= SYNC_ONLINE;
            end else begin
              state_q <= SYNC_COUNTING;
              cnt_q   <= dir_delay[d] - lpif_link_pkg::delay_t'(2);
            end
          end
          SYNC_COUNTING: begin
            if (cnt_q == '0) begin
              state_q <= SYNC_ONLINE;
            end else begin
              cnt_q <= cnt_q - 1'b1;
            end
          end
          SYNC_ONLINE: state_q <= SYNC_ONLINE;
          default:     state_q <= SYNC_OFFLINE;
        endcase
      end
    end

    assign dir_level[d] = (state_q == SYNC_ONLINE);

    // Delayed level drops one edge after its raw level
    a_level_follows_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
      !dir_online[d] |=> !dir_level[d]);
  end

  assign tx_online_delay = dir_level[0];
  assign rx_online_delay = dir_level[1];

  ////////////////////////////////////////
  // Persistent strobe and marker
  ////////////////////////////////////////

  // Period of zero treated as one
  assign stb_period = (delay_z_value == '0) ? lpif_link_pkg::delay_t'(1) : delay_z_value;

  // Phase 0 on the first online cycle
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online_delay) begin
      stb_phase <= '0;
    end else if (stb_phase >= stb_period - 1'b1) begin
      stb_phase <= '0;
    end else begin
      stb_phase <= stb_phase + 1'b1;
    end
  end

  assign tx_auto_stb_userbit = tx_online_delay && ((stb_phase == '0) || tx_stb_userbit);
  assign tx_auto_mrk_userbit = tx_online_delay ? tx_mrk_userbit : '0;

  // Strobe gone one edge after tx_online drops
  a_stb_offline: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online |=> !tx_auto_stb_userbit);

  // Same status word on both sides
  assign link_status = {12'h0, tx_online_delay, rx_online_delay, 18'h0};
  assign tx_downstream_debug_status = link_status;
  assign rx_upstream_debug_status   = link_status;

endmodule

`default_nettype wire

// File: source/lpif_user_pack.sv
`default_nettype none

module lpif_user_pack (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  logic                   rx_online_delay,
  // Downstream transfer
  input  lpif_link_pkg::state_t  dstrm_state,
  input  lpif_link_pkg::protid_t dstrm_protid,
  input  lpif_link_pkg::data_t   dstrm_data,
  input  lpif_link_pkg::dvalid_t dstrm_dvalid,
  input  lpif_link_pkg::crc_t    dstrm_crc,
  input  lpif_link_pkg::crcv_t   dstrm_crc_valid,
  input  lpif_link_pkg::valid_t  dstrm_valid,
  // Received word from the lanes
  input  lpif_link_pkg::word_t   rx_word,
  output lpif_link_pkg::word_t   tx_word,
  // Upstream transfer
  output lpif_link_pkg::state_t  ustrm_state,
  output lpif_link_pkg::protid_t ustrm_protid,
  output lpif_link_pkg::data_t   ustrm_data,
  output lpif_link_pkg::dvalid_t ustrm_dvalid,
  output lpif_link_pkg::crc_t    ustrm_crc,
  output lpif_link_pkg::crcv_t   ustrm_crc_valid,
  output lpif_link_pkg::valid_t  ustrm_valid
);

  // Used field bits, the rest of the word is pad
  localparam int FIELD_W = $bits(lpif_link_pkg::state_t) + $bits(lpif_link_pkg::protid_t)
                         + $bits(lpif_link_pkg::data_t) + $bits(lpif_link_pkg::dvalid_t)
                         + $bits(lpif_link_pkg::crc_t) + $bits(lpif_link_pkg::crcv_t)
                         + $bits(lpif_link_pkg::valid_t);
  localparam int PAD_W   = $bits(lpif_link_pkg::word_t) - FIELD_W;

  ////////////////////////////////////////
  // Tx pack
  ////////////////////////////////////////

  // Taken every cycle, valid bits ride along
  always_ff @(posedge clk_wr) begin
    tx_word <= {{PAD_W{1'b0}}, dstrm_state, dstrm_protid, dstrm_valid,
                dstrm_dvalid, dstrm_crc_valid, dstrm_crc, dstrm_data};
  end

  ////////////////////////////////////////
  // Rx unpack
  ////////////////////////////////////////

  // Outputs held at zero while rx is not online
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online_delay) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_valid     <= '0;
      ustrm_dvalid    <= '0;
      ustrm_crc_valid <= '0;
      ustrm_crc       <= '0;
      ustrm_data      <= '0;
    end else begin
      // Pad bits dropped here
      {ustrm_state, ustrm_protid, ustrm_valid, ustrm_dvalid,
       ustrm_crc_valid, ustrm_crc, ustrm_data} <= rx_word[FIELD_W-1:0];
    end
  end

  // Far side sends zero pad, so nonzero pad means broken lanes
  a_pad_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> rx_word[$bits(lpif_link_pkg::word_t)-1 -: PAD_W] == '0);

endmodule

`default_nettype wire

// File: source/lpif_phy_concat.sv
`include "lpif_link_cfg.svh"

`default_nettype none

module lpif_phy_concat (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  // From auto sync
  input  logic                  tx_online_delay,
  input  logic                  tx_auto_stb_userbit,
  input  lpif_link_pkg::mrk_t   tx_auto_mrk_userbit,
  // Packed transfer word
  input  lpif_link_pkg::word_t  tx_word,
  // PHY lanes in
  input  lpif_link_pkg::lane_t  rx_phy0,
  input  lpif_link_pkg::lane_t  rx_phy1,
  input  lpif_link_pkg::lane_t  rx_phy2,
  input  lpif_link_pkg::lane_t  rx_phy3,
  // PHY lanes out
  output lpif_link_pkg::lane_t  tx_phy0,
  output lpif_link_pkg::lane_t  tx_phy1,
  output lpif_link_pkg::lane_t  tx_phy2,
  output lpif_link_pkg::lane_t  tx_phy3,
  // Reassembled word
  output lpif_link_pkg::word_t  rx_word
);

  localparam int LANES   = `LPIF_LANES;
  localparam int PAY_W   = `LPIF_LANE_PAY_W;
  localparam int MRK_W   = `LPIF_MRK_W;
  // Strobe right above the payload, marker on top
  localparam int STB_POS = PAY_W;
  localparam int MRK_LSB = PAY_W + 1;

  lpif_link_pkg::lane_t tx_lane_d [LANES];
  lpif_link_pkg::lane_t tx_lane_q [LANES];
  lpif_link_pkg::lane_t rx_lane   [LANES];

  ////////////////////////////////////////
  // Tx lane split
  ////////////////////////////////////////

  // Lane n takes word bits from n*PAY_W upward
  always_comb begin
    for (int n = 0; n < LANES; n++) begin
      tx_lane_d[n]              = '0;
      tx_lane_d[n][PAY_W-1:0]   = tx_word[n*PAY_W +: PAY_W];
      // Strobe only on lane 0
      if (n == 0) begin
        tx_lane_d[n][STB_POS] = tx_auto_stb_userbit;
      end
      // Marker only on the last lane
      if (n == LANES - 1) begin
        tx_lane_d[n][MRK_LSB +: MRK_W] = tx_auto_mrk_userbit;
      end
    end
  end

  // Same stage for payload, strobe and marker
  always_ff @(posedge clk_wr) begin
    for (int n = 0; n < LANES; n++) begin
      if (!rst_n || !tx_online_delay) begin
        tx_lane_q[n] <= '0;
      end else begin
        tx_lane_q[n] <= tx_lane_d[n];
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  // Lanes quiet on the edge after tx goes offline
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> (tx_phy0 == '0) && (tx_phy1 == '0)
                         && (tx_phy2 == '0) && (tx_phy3 == '0));

  ////////////////////////////////////////
  // Rx lane strip
  ////////////////////////////////////////

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Strobe and marker bits discarded
  always_ff @(posedge clk_wr) begin
    for (int n = 0; n < LANES; n++) begin
      rx_word[n*PAY_W +: PAY_W] <= rx_lane[n][PAY_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_link_master_top.sv
`default_nettype none

module lpif_link_master_top (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,
  // PHY lanes
  output lpif_link_pkg::lane_t   tx_phy0,
  input  lpif_link_pkg::lane_t   rx_phy0,
  output lpif_link_pkg::lane_t   tx_phy1,
  input  lpif_link_pkg::lane_t   rx_phy1,
  output lpif_link_pkg::lane_t   tx_phy2,
  input  lpif_link_pkg::lane_t   rx_phy2,
  output lpif_link_pkg::lane_t   tx_phy3,
  input  lpif_link_pkg::lane_t   rx_phy3,
  // Downstream channel
  input  lpif_link_pkg::state_t  dstrm_state,
  input  lpif_link_pkg::protid_t dstrm_protid,
  input  lpif_link_pkg::data_t   dstrm_data,
  input  lpif_link_pkg::dvalid_t dstrm_dvalid,
  input  lpif_link_pkg::crc_t    dstrm_crc,
  input  lpif_link_pkg::crcv_t   dstrm_crc_valid,
  input  lpif_link_pkg::valid_t  dstrm_valid,
  // Upstream channel
  output lpif_link_pkg::state_t  ustrm_state,
  output lpif_link_pkg::protid_t ustrm_protid,
  output lpif_link_pkg::data_t   ustrm_data,
  output lpif_link_pkg::dvalid_t ustrm_dvalid,
  output lpif_link_pkg::crc_t    ustrm_crc,
  output lpif_link_pkg::crcv_t   ustrm_crc_valid,
  output lpif_link_pkg::valid_t  ustrm_valid,
  // Status
  output lpif_link_pkg::dbg_t    tx_downstream_debug_status,
  output lpif_link_pkg::dbg_t    rx_upstream_debug_status,
  // Config
  input  lpif_link_pkg::mrk_t    tx_mrk_userbit,
  input  logic                   tx_stb_userbit,
  input  lpif_link_pkg::delay_t  delay_x_value,
  input  lpif_link_pkg::delay_t  delay_y_value,
  input  lpif_link_pkg::delay_t  delay_z_value
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  logic                 tx_online_delay;
  logic                 rx_online_delay;
  logic                 tx_auto_stb_userbit;
  lpif_link_pkg::mrk_t  tx_auto_mrk_userbit;
  lpif_link_pkg::word_t tx_word;
  lpif_link_pkg::word_t rx_word;

  // Online delays, strobe and marker, status words
  lpif_auto_sync i_auto_sync (
    .clk_wr, .rst_n, .tx_online, .rx_online,
    .delay_x_value, .delay_y_value, .delay_z_value,
    .tx_mrk_userbit, .tx_stb_userbit,
    .tx_online_delay, .rx_online_delay,
    .tx_auto_stb_userbit, .tx_auto_mrk_userbit,
    .tx_downstream_debug_status, .rx_upstream_debug_status
  );

  // Field pack and unpack
  lpif_user_pack i_user_pack (
    .clk_wr, .rst_n, .rx_online_delay,
    .dstrm_state, .dstrm_protid, .dstrm_data, .dstrm_dvalid,
    .dstrm_crc, .dstrm_crc_valid, .dstrm_valid,
    .rx_word, .tx_word,
    .ustrm_state, .ustrm_protid, .ustrm_data, .ustrm_dvalid,
    .ustrm_crc, .ustrm_crc_valid, .ustrm_valid
  );

  // Lane split and reassembly
  lpif_phy_concat i_phy_concat (
    .clk_wr, .rst_n, .tx_online_delay,
    .tx_auto_stb_userbit, .tx_auto_mrk_userbit, .tx_word,
    .rx_phy0, .rx_phy1, .rx_phy2, .rx_phy3,
    .tx_phy0, .tx_phy1, .tx_phy2, .tx_phy3,
    .rx_word
  );

endmodule

`default_nettype wire

// File: bench/lpif_link_tb.sv
`include "lpif_link_cfg.svh"

`default_nettype none

module lpif_link_tb;

  // Four lane words side by side, lane 0 lowest
  typedef logic [`LPIF_LANES-1:0][`LPIF_LANE_W-1:0] lane_set_t;

  logic                   clk_wr;
  logic                   rst_n;
  logic                   tx_online;
  logic                   rx_online;
  lpif_link_pkg::lane_t   tx_phy [`LPIF_LANES];
  lpif_link_pkg::lane_t   rx_phy [`LPIF_LANES];
  lpif_link_pkg::state_t  dstrm_state, ustrm_state;
  lpif_link_pkg::protid_t dstrm_protid, ustrm_protid;
  lpif_link_pkg::data_t   dstrm_data, ustrm_data;
  lpif_link_pkg::dvalid_t dstrm_dvalid, ustrm_dvalid;
  lpif_link_pkg::crc_t    dstrm_crc, ustrm_crc;
  lpif_link_pkg::crcv_t   dstrm_crc_valid, ustrm_crc_valid;
  lpif_link_pkg::valid_t  dstrm_valid, ustrm_valid;
  lpif_link_pkg::dbg_t    tx_downstream_debug_status;
  lpif_link_pkg::dbg_t    rx_upstream_debug_status;
  lpif_link_pkg::mrk_t    tx_mrk_userbit;
  logic                   tx_stb_userbit;
  lpif_link_pkg::delay_t  delay_x_value, delay_y_value, delay_z_value;

  // Lane loopback with direct injection override
  logic                   inject;
  lane_set_t              inj_lanes;
  // Stimulus history, newest at the back
  lpif_link_pkg::word_t   history [$];
  logic                   loop_check;
  integer                 seed;
  int                     tests, checks, errors, err_mark;

  lpif_link_master_top i_dut (
    .clk_wr, .rst_n, .tx_online, .rx_online,
    .tx_phy0(tx_phy[0]), .tx_phy1(tx_phy[1]), .tx_phy2(tx_phy[2]), .tx_phy3(tx_phy[3]),
    .rx_phy0(rx_phy[0]), .rx_phy1(rx_phy[1]), .rx_phy2(rx_phy[2]), .rx_phy3(rx_phy[3]),
    .dstrm_state, .dstrm_protid, .dstrm_data, .dstrm_dvalid,
    .dstrm_crc, .dstrm_crc_valid, .dstrm_valid,
    .ustrm_state, .ustrm_protid, .ustrm_data, .ustrm_dvalid,
    .ustrm_crc, .ustrm_crc_valid, .ustrm_valid,
    .tx_downstream_debug_status, .rx_upstream_debug_status,
    .tx_mrk_userbit, .tx_stb_userbit, .delay_x_value, .delay_y_value, .delay_z_value
  );

  for (genvar n = 0; n < `LPIF_LANES; n++) begin : g_loop
    assign rx_phy[n] = inject ? inj_lanes[n] : tx_phy[n];
  end

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // From LSB data, crc, crc_valid, dvalid, valid, protid, state, pad
  function automatic lpif_link_pkg::word_t pack_word(
    lpif_link_pkg::state_t st, lpif_link_pkg::protid_t pr, lpif_link_pkg::data_t da,
    lpif_link_pkg::dvalid_t dv, lpif_link_pkg::crc_t cr, lpif_link_pkg::crcv_t cv,
    lpif_link_pkg::valid_t va);
    return {2'b00, st, pr, va, dv, cv, cr, da};
  endfunction

  // Lane n gets 41 word bits from n*41, strobe on lane 0, marker on lane 3
  function automatic lane_set_t expected_lanes(lpif_link_pkg::word_t w, logic stb,
                                               lpif_link_pkg::mrk_t mrk);
    lane_set_t l;
    for (int n = 0; n < `LPIF_LANES; n++) begin
      l[n] = '0;
      l[n][`LPIF_LANE_PAY_W-1:0] = w[n*`LPIF_LANE_PAY_W +: `LPIF_LANE_PAY_W];
    end
    l[0][`LPIF_LANE_PAY_W] = stb;
    l[`LPIF_LANES-1][`LPIF_LANE_W-1 -: `LPIF_MRK_W] = mrk;
    return l;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_value(input string name, input lpif_link_pkg::word_t got,
                             input lpif_link_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_lane(input string name, input lpif_link_pkg::lane_t got,
                              input lpif_link_pkg::lane_t exp);
    check_value(name, lpif_link_pkg::word_t'(got), lpif_link_pkg::word_t'(exp));
  endtask

  task automatic compare_level(input string name, input logic got, input logic exp);
    check_value(name, lpif_link_pkg::word_t'(got), lpif_link_pkg::word_t'(exp));
  endtask

  task automatic compare_dbg(input string name, input lpif_link_pkg::dbg_t got,
                             input lpif_link_pkg::dbg_t exp);
    check_value(name, lpif_link_pkg::word_t'(got), lpif_link_pkg::word_t'(exp));
  endtask

  // One check per ustrm field
  task automatic compare_word_fields(input lpif_link_pkg::word_t exp);
    lpif_link_pkg::state_t  st;
    lpif_link_pkg::protid_t pr;
    lpif_link_pkg::data_t   da;
    lpif_link_pkg::dvalid_t dv;
    lpif_link_pkg::crc_t    cr;
    lpif_link_pkg::crcv_t   cv;
    lpif_link_pkg::valid_t  va;
    // Two pad bits on top dropped
    {st, pr, va, dv, cv, cr, da} = exp[`LPIF_WORD_W-3:0];
    check_value("ustrm_state", ustrm_state, st);
    check_value("ustrm_protid", ustrm_protid, pr);
    check_value("ustrm_data", ustrm_data, da);
    check_value("ustrm_dvalid", ustrm_dvalid, dv);
    check_value("ustrm_crc", ustrm_crc, cr);
    check_value("ustrm_crc_valid", ustrm_crc_valid, cv);
    check_value("ustrm_valid", ustrm_valid, va);
  endtask

  task automatic check_lanes(input lane_set_t exp);
    for (int n = 0; n < `LPIF_LANES; n++) begin
      compare_lane($sformatf("tx_phy%0d", n), tx_phy[n], exp[n]);
    end
  endtask

  // Bit 19 tx level, bit 18 rx level
  task automatic check_status(input logic tx_lvl, input logic rx_lvl);
    lpif_link_pkg::dbg_t exp;
    exp = '0;
    exp[19] = tx_lvl;
    exp[18] = rx_lvl;
    compare_dbg("tx_downstream_debug_status", tx_downstream_debug_status, exp);
    compare_dbg("rx_upstream_debug_status", rx_upstream_debug_status, exp);
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Inputs change 2 units after the rising edge
  task automatic step();
    @(posedge clk_wr);
    #2;
  endtask

  task automatic drive_random();
    dstrm_state     = lpif_link_pkg::state_t'($random(seed));
    dstrm_protid    = lpif_link_pkg::protid_t'($random(seed));
    dstrm_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    dstrm_dvalid    = lpif_link_pkg::dvalid_t'($random(seed));
    dstrm_crc       = lpif_link_pkg::crc_t'($random(seed));
    dstrm_crc_valid = lpif_link_pkg::crcv_t'($random(seed));
    dstrm_valid     = lpif_link_pkg::valid_t'($random(seed));
  endtask

  task automatic wait_status_bit(input int idx, input logic val, input string what);
    int n;
    n = 0;
    while (tx_downstream_debug_status[idx] !== val && n < 50) begin
      step();
      n++;
    end
    if (tx_downstream_debug_status[idx] !== val) begin
      $display("timeout: %s did not reach %b within 50 cycles", what, val);
      $display("Verification failed");
      $finish;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // Loopback compare against the transfer sent 4 cycles earlier
  always @(negedge clk_wr) begin
    history.push_back(pack_word(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                                dstrm_crc, dstrm_crc_valid, dstrm_valid));
    if (history.size() > 8) begin
      void'(history.pop_front());
    end
    if (loop_check && history.size() >= 5) begin
      compare_word_fields(history[history.size()-5]);
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int i;
    int k;
    int n;
    lpif_link_pkg::word_t w;
    lane_set_t exp;
    seed = 32'hd919;
    tests = 0;
    checks = 0;
    errors = 0;
    err_mark = 0;
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    inject = 1'b0;
    inj_lanes = '0;
    loop_check = 1'b0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    dstrm_state = '0;
    dstrm_protid = '0;
    dstrm_data = '0;
    dstrm_dvalid = '0;
    dstrm_crc = '0;
    dstrm_crc_valid = '0;
    dstrm_valid = '0;
    repeat (10) step();
    rst_n = 1'b1;

    // Offline, lanes and ustrm stay quiet
    for (i = 0; i < 6; i++) begin
      step();
      check_lanes('0);
      compare_word_fields('0);
      check_status(1'b0, 1'b0);
      drive_random();
    end
    finish_test("reset and offline");

    // Period 1 keeps the strobe phase at 0
    delay_y_value = 16'd7;
    delay_x_value = 16'd3;
    delay_z_value = 16'd1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    for (i = 1; i <= 8; i++) begin
      step();
      check_status(i >= 7, i >= 3);
    end
    tx_online = 1'b0;
    step();
    check_status(1'b0, 1'b1);
    step();
    check_lanes('0);
    tx_online = 1'b1;
    wait_status_bit(19, 1'b1, "tx_online_delay");
    finish_test("online delays");

    // Lanes hold the word sent 2 cycles back
    tx_mrk_userbit = lpif_link_pkg::mrk_t'($random(seed));
    for (k = 0; k < 4; k++) begin
      n = 3 + ({$random(seed)} % 6);
      repeat (n) begin
        step();
        drive_random();
      end
      step();
      exp = expected_lanes(history[history.size()-2], 1'b1, tx_mrk_userbit);
      check_lanes(exp);
      drive_random();
    end
    finish_test("lane mapping");

    // Phase restarts from 0, so the strobe shows on the first edge
    delay_z_value = 16'd5;
    for (i = 1; i <= 15; i++) begin
      step();
      compare_level("tx_phy0 strobe", tx_phy[0][`LPIF_LANE_PAY_W], ((i - 1) % 5) == 0);
    end
    tx_stb_userbit = 1'b1;
    for (i = 1; i <= 8; i++) begin
      step();
      compare_level("tx_phy0 strobe", tx_phy[0][`LPIF_LANE_PAY_W], 1'b1);
    end
    tx_stb_userbit = 1'b0;
    finish_test("persistent strobe");

    loop_check = 1'b1;
    for (i = 0; i < 200; i++) begin
      step();
      drive_random();
      if (i % 7 == 3) begin
        dstrm_valid = '0;
      end
    end
    // Drain the last transfers through the compare
    repeat (5) step();
    loop_check = 1'b0;
    finish_test("loopback data");

    rx_online = 1'b0;
    wait_status_bit(18, 1'b0, "rx_online_delay");
    // First check lands 2 cycles after the level fell
    repeat (2) step();
    for (i = 0; i < 6; i++) begin
      compare_word_fields('0);
      drive_random();
      step();
    end
    rx_online = 1'b1;
    wait_status_bit(18, 1'b1, "rx_online_delay");
    // Strobe and marker bits set on every lane
    drive_random();
    w = pack_word(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                  dstrm_crc, dstrm_crc_valid, dstrm_valid);
    inj_lanes = expected_lanes(w, 1'b1, 2'b11);
    for (n = 0; n < `LPIF_LANES; n++) begin
      inj_lanes[n][`LPIF_LANE_W-1:`LPIF_LANE_PAY_W] = '1;
    end
    inject = 1'b1;
    repeat (2) step();
    compare_word_fields(w);
    inject = 1'b0;
    finish_test("rx gating");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/lpif_link_pkg.sv
source/lpif_auto_sync.sv
source/lpif_user_pack.sv
source/lpif_phy_concat.sv
source/lpif_link_master_top.sv
bench/lpif_link_tb.sv

// File: Bender.yml
package:
  name: lpif_link

export_include_dirs:
  - source

sources:
  # RTL in compile order
  - include_dirs:
      - source
    files:
      - source/lpif_link_pkg.sv
      - source/lpif_auto_sync.sv
      - source/lpif_user_pack.sv
      - source/lpif_phy_concat.sv
      - source/lpif_link_master_top.sv

  # Testbench
  - target: test
    include_dirs:
      - source
    files:
      - bench/lpif_link_tb.sv
